// ==== src/tm_defines.svh ====
// ---------------------------------------------------------------------
// Widths, counts and PIO address map of the priority scheduler
// control bank. Values are global, so a change here resizes every
// table and the host address decode together.
// ---------------------------------------------------------------------

`ifndef TM_DEFINES_SVH
`define TM_DEFINES_SVH

// Bus and table sizing.
`define PIO_NBITS                32     // PIO address and data width.
`define FIRST_LVL_SCH_ID_NBITS   6      // 64 words per table.
`define FIRST_LVL_QUEUE_ID_NBITS 8      // Two queue ids per word.
`define NUM_PRI                  8      // One table per priority level.

// ---------------------------------------------------------------------
// PIO address map
// ---------------------------------------------------------------------
`define PRI_SCH_REGION           21'h00001
`define PIO_REGION_MSB           31
`define PIO_REGION_LSB           11
`define PIO_SEL_MSB              10     // Table select.
`define PIO_SEL_LSB              8
`define PIO_IDX_MSB              7      // Word index within a table.
`define PIO_IDX_LSB              2      // Byte lane bits 1:0 are ignored.

`endif

// ==== src/tm_pkg.sv ====
// ---------------------------------------------------------------------
// Types shared by the control bank. Widths follow tm_defines.svh.
// ---------------------------------------------------------------------

`default_nettype none

`include "tm_defines.svh"

package tm_pkg;

        // PIO address or data word.
        typedef logic [`PIO_NBITS-1:0] pio_word_t;

        // First-level scheduler id, the table index.
        typedef logic [`FIRST_LVL_SCH_ID_NBITS-1:0] sch_id_t;

        // Control word, two packed first-level queue ids.
        typedef logic [(`FIRST_LVL_QUEUE_ID_NBITS << 1)-1:0] ctrl_word_t;

        // One-hot priority table select.
        typedef logic [`NUM_PRI-1:0] pri_ms_t;

endpackage

`default_nettype wire

// ==== src/pio_mem.sv ====
// ---------------------------------------------------------------------
// One control table with a PIO write port and one arbitrated read
// port. The engine read always wins; a PIO read waits as pending
// until the engine port is idle. Only one PIO read may be pending.
// Read data is registered, table contents are not reset.
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tm_defines.svh"

module pio_mem import tm_pkg::*; #(
        parameter int WIDTH       = (`FIRST_LVL_QUEUE_ID_NBITS << 1),
        parameter int DEPTH_NBITS = `FIRST_LVL_SCH_ID_NBITS
) (
        input  wire                      clk,
        input  wire                      rst_n,

        // PIO side.
        input  wire pio_word_t           reg_addr,
        input  wire                      reg_rd,
        input  wire                      reg_ms,
        input  wire                      wr,
        input  wire [DEPTH_NBITS-1:0]    waddr,
        input  wire [WIDTH-1:0]          wdata,

        // Scheduler engine side.
        input  wire                      app_mem_rd,
        input  wire [DEPTH_NBITS-1:0]    app_mem_raddr,

        output logic                     mem_ack,
        output pio_word_t                mem_rdata,
        output logic                     app_mem_ack,
        output logic [WIDTH-1:0]         app_mem_rdata
);

        localparam int DEPTH = 1 << DEPTH_NBITS;

        logic [WIDTH-1:0]       mem [DEPTH];
        logic                   pend;           // PIO read waiting for the port.
        logic [DEPTH_NBITS-1:0] pend_addr;
        logic                   pio_req;
        logic [DEPTH_NBITS-1:0] pio_addr;
        logic                   pio_grant;
        logic [DEPTH_NBITS-1:0] rd_addr;
        logic [WIDTH-1:0]       rd_q;

        // -------------------------------------------------------------
        // Read port arbitration
        // -------------------------------------------------------------
        assign pio_req   = pend | (reg_rd & reg_ms);
        assign pio_addr  = pend ? pend_addr : reg_addr[`PIO_IDX_LSB +: DEPTH_NBITS];
        assign pio_grant = pio_req & ~app_mem_rd;       // Engine has priority.
        assign rd_addr   = app_mem_rd ? app_mem_raddr : pio_addr;

        // Write port, PIO only.
        always_ff @(posedge clk) begin
                if (wr) begin
                        mem[waddr] <= wdata;
                end
        end

        // Single registered read, shared by both requesters.
        always_ff @(posedge clk) begin
                if (app_mem_rd | pio_grant) begin
                        rd_q <= mem[rd_addr];
                end
        end

        // Hold the index of a stalled PIO read.
        always_ff @(posedge clk) begin
                if (!pend) begin
                        pend_addr <= reg_addr[`PIO_IDX_LSB +: DEPTH_NBITS];
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pend        <= 1'b0;
                        mem_ack     <= 1'b0;
                        app_mem_ack <= 1'b0;
                end else begin
                        pend        <= pio_req & app_mem_rd;    // Lost to the engine.
                        mem_ack     <= pio_grant;
                        app_mem_ack <= app_mem_rd;
                end
        end

        // PIO data is zero-extended to the bus width.
        assign mem_rdata     = {{(`PIO_NBITS - WIDTH){1'b0}}, rd_q};
        assign app_mem_rdata = rd_q;

endmodule

`default_nettype wire

// ==== src/tm_sch_pri_mem.sv ====
// ---------------------------------------------------------------------
// Bank of eight priority control tables. PIO writes are registered
// once and broadcast; the registered strobe is masked by the table
// select. Each table keeps its own engine read port.
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tm_defines.svh"

module tm_sch_pri_mem import tm_pkg::*; (
        input  wire                     clk,
        input  wire                     rst_n,

        // Host PIO side.
        input  wire pio_word_t          reg_addr,
        input  wire pio_word_t          reg_din,
        input  wire                     reg_rd,
        input  wire                     reg_wr,
        input  wire pri_ms_t            reg_ms_pri_sch_ctrl,

        // Scheduler engine read ports, one per priority.
        input  wire [`NUM_PRI-1:0]      app_rd,
        input  wire sch_id_t            app_raddr [`NUM_PRI-1:0],

        output logic [`NUM_PRI-1:0]     mem_ack,
        output pio_word_t               mem_rdata [`NUM_PRI-1:0],
        output logic [`NUM_PRI-1:0]     app_ack,
        output ctrl_word_t              app_rdata [`NUM_PRI-1:0]
);

        pri_ms_t    ctrl_wr;            // Per-table write strobe.
        sch_id_t    ctrl_waddr;
        ctrl_word_t ctrl_wdata;

        // -------------------------------------------------------------
        // Write staging
        // -------------------------------------------------------------
        always_ff @(posedge clk) begin
                ctrl_waddr <= reg_addr[`PIO_IDX_MSB:`PIO_IDX_LSB];
                ctrl_wdata <= reg_din[$bits(ctrl_word_t)-1:0];  // Upper bits dropped.
        end

        // An unmapped address gives an all-zero select, so no table is written.
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ctrl_wr <= '0;
                end else begin
                        ctrl_wr <= {`NUM_PRI{reg_wr}} & reg_ms_pri_sch_ctrl;
                end
        end

        // -------------------------------------------------------------
        // Table instances
        // -------------------------------------------------------------
        for (genvar i = 0; i < `NUM_PRI; i++) begin : g_pri
                pio_mem #(
                        .WIDTH       ($bits(ctrl_word_t)),
                        .DEPTH_NBITS ($bits(sch_id_t))
                ) u_pio_mem (
                        .clk           (clk),
                        .rst_n         (rst_n),
                        .reg_addr      (reg_addr),
                        .reg_rd        (reg_rd),
                        .reg_ms        (reg_ms_pri_sch_ctrl[i]),
                        .wr            (ctrl_wr[i]),
                        .waddr         (ctrl_waddr),
                        .wdata         (ctrl_wdata),
                        .app_mem_rd    (app_rd[i]),
                        .app_mem_raddr (app_raddr[i]),
                        .mem_ack       (mem_ack[i]),
                        .mem_rdata     (mem_rdata[i]),
                        .app_mem_ack   (app_ack[i]),
                        .app_mem_rdata (app_rdata[i])
                );
        end

endmodule

`default_nettype wire

// ==== src/pio_decode.sv ====
// ---------------------------------------------------------------------
// Host address decode for the control bank. Assumes one PIO read
// outstanding, so at most one table ack is high in any cycle.
// Reads outside the region are acked next cycle with zero data.
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tm_defines.svh"

module pio_decode import tm_pkg::*; (
        input  wire                     clk,
        input  wire                     rst_n,

        input  wire pio_word_t          reg_addr,
        input  wire                     reg_rd,
        input  wire [`NUM_PRI-1:0]      mem_ack,
        input  wire pio_word_t          mem_rdata [`NUM_PRI-1:0],

        output pri_ms_t                 reg_ms,
        output logic                    reg_ack,
        output pio_word_t               reg_rdata
);

        logic region_hit;
        logic miss_ack;                 // Ack for an unmapped read.

        assign region_hit = (reg_addr[`PIO_REGION_MSB:`PIO_REGION_LSB] == `PRI_SCH_REGION);

        // One-hot table select, zero outside the region.
        assign reg_ms = region_hit ?
                        (pri_ms_t'(1) << reg_addr[`PIO_SEL_MSB:`PIO_SEL_LSB]) : '0;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        miss_ack <= 1'b0;
                end else begin
                        miss_ack <= reg_rd & ~region_hit;
                end
        end

        assign reg_ack = (|mem_ack) | miss_ack;

        // AND-OR mux of the acked table; zero on a miss.
        always_comb begin
                reg_rdata = '0;
                for (int i = 0; i < `NUM_PRI; i++) begin
                        if (mem_ack[i]) begin
                                reg_rdata = reg_rdata | mem_rdata[i];
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/tm_pri_sch_ctrl_top.sv ====
// ---------------------------------------------------------------------
// Priority scheduler control memory top. Host PIO uses one-cycle
// strobes with one read outstanding; writes are not acked.
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tm_defines.svh"

module tm_pri_sch_ctrl_top import tm_pkg::*; (
        input  wire                     clk,
        input  wire                     rst_n,

        // Host PIO bus.
        input  wire pio_word_t          reg_addr,
        input  wire pio_word_t          reg_din,
        input  wire                     reg_rd,
        input  wire                     reg_wr,
        output logic                    reg_ack,
        output pio_word_t               reg_rdata,

        // Scheduler engines.
        input  wire [`NUM_PRI-1:0]      app_rd,
        input  wire sch_id_t            app_raddr [`NUM_PRI-1:0],
        output logic [`NUM_PRI-1:0]     app_ack,
        output ctrl_word_t              app_rdata [`NUM_PRI-1:0]
);

        pri_ms_t             reg_ms;
        logic [`NUM_PRI-1:0] mem_ack;
        pio_word_t           mem_rdata [`NUM_PRI-1:0];

        pio_decode u_pio_decode (
                .clk       (clk),
                .rst_n     (rst_n),
                .reg_addr  (reg_addr),
                .reg_rd    (reg_rd),
                .mem_ack   (mem_ack),
                .mem_rdata (mem_rdata),
                .reg_ms    (reg_ms),
                .reg_ack   (reg_ack),
                .reg_rdata (reg_rdata)
        );

        tm_sch_pri_mem u_tm_sch_pri_mem (
                .clk                 (clk),
                .rst_n               (rst_n),
                .reg_addr            (reg_addr),
                .reg_din             (reg_din),
                .reg_rd              (reg_rd),
                .reg_wr              (reg_wr),
                .reg_ms_pri_sch_ctrl (reg_ms),
                .app_rd              (app_rd),
                .app_raddr           (app_raddr),
                .mem_ack             (mem_ack),
                .mem_rdata           (mem_rdata),
                .app_ack             (app_ack),
                .app_rdata           (app_rdata)
        );

endmodule

`default_nettype wire

// ==== verification/tb_tm_pri_sch_ctrl.sv ====
// ---------------------------------------------------------------------
// Random testbench for the priority scheduler control bank. All
// tables are filled first, since table words are not reset. The
// model is updated when a write is issued; reads wait two cycles.
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tm_defines.svh"

module tb_tm_pri_sch_ctrl import tm_pkg::*; ();

        localparam int DEPTH      = 1 << `FIRST_LVL_SCH_ID_NBITS;
        localparam int MAX_CYCLES = 4000;

        logic clk = 1'b0;
        logic rst_n;
        pio_word_t reg_addr, reg_din, reg_rdata;
        logic reg_rd, reg_wr, reg_ack;
        logic [`NUM_PRI-1:0] app_rd, app_ack;
        sch_id_t app_raddr [`NUM_PRI-1:0];
        ctrl_word_t app_rdata [`NUM_PRI-1:0];

        ctrl_word_t model [`NUM_PRI][DEPTH];    // Mirror of all tables.
        integer seed = 32'he315;
        int errors = 0;
        int checks = 0;
        int cycles = 0;

        tm_pri_sch_ctrl_top tm_pri_sch_ctrl_top_i (.*);

        always #2 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == MAX_CYCLES) begin
                        $display("Timeout: the run did not finish in %0d cycles.", MAX_CYCLES);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        // ---------------------------------------------------------------------
        // Helpers
        // ---------------------------------------------------------------------
        task automatic check_value(input string name, input pio_word_t actual,
                                   input pio_word_t expected);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("Error at %0t: %s is 0x%h, expected 0x%h.",
                                 $time, name, actual, expected);
                end
        endtask

        function automatic pio_word_t rand32();
                rand32 = $random(seed);
        endfunction

        function automatic logic in_region(input pio_word_t a);
                return a[`PIO_REGION_MSB:`PIO_REGION_LSB] == `PRI_SCH_REGION;
        endfunction

        function automatic pio_word_t unmapped_addr();
                pio_word_t a;
                a = rand32();
                if (in_region(a)) begin
                        a[31] = 1'b1;
                end
                return a;
        endfunction

        // Readback is the table word, zero-extended, or zero off the region.
        function automatic pio_word_t expect_pio(input pio_word_t a);
                if (!in_region(a)) begin
                        return '0;
                end
                return pio_word_t'(model[a[`PIO_SEL_MSB:`PIO_SEL_LSB]]
                                        [a[`PIO_IDX_MSB:`PIO_IDX_LSB]]);
        endfunction

        // All tasks start and return on a falling edge.
        task automatic pio_write(input pio_word_t addr, input pio_word_t data);
                reg_addr = addr;
                reg_din  = data;
                reg_wr   = 1'b1;
                @(negedge clk);
                reg_wr = 1'b0;
                if (in_region(addr)) begin
                        model[addr[`PIO_SEL_MSB:`PIO_SEL_LSB]][addr[`PIO_IDX_MSB:`PIO_IDX_LSB]] =
                                data[15:0];
                end
        endtask

        task automatic pio_read(input pio_word_t addr, output pio_word_t data);
                reg_addr = addr;
                reg_rd   = 1'b1;
                @(negedge clk);
                reg_rd = 1'b0;
                while (!reg_ack) @(negedge clk);        // Variable latency.
                data = reg_rdata;
        endtask

        task automatic check_engine(input logic [`NUM_PRI-1:0] mask,
                                    input sch_id_t idx [`NUM_PRI]);
                check_value("app_ack", pio_word_t'(app_ack), pio_word_t'(mask));
                for (int i = 0; i < `NUM_PRI; i++) begin
                        if (mask[i]) begin
                                check_value($sformatf("app_rdata[%0d]", i),
                                            pio_word_t'(app_rdata[i]),
                                            pio_word_t'(model[i][idx[i]]));
                        end
                end
        endtask

        // Random engine reads, or a sweep of every index on all tables.
        task automatic engine_reads(input int n, input bit sweep);
                logic [`NUM_PRI-1:0] mask;
                sch_id_t idx [`NUM_PRI];
                pio_word_t r;
                mask = '0;
                for (int k = 0; k <= n; k++) begin
                        if (k > 0) begin
                                check_engine(mask, idx);        // Ack one cycle later.
                        end
                        r = rand32();
                        mask = (k == n) ? '0 : (sweep ? '1 : r[7:0]);
                        for (int i = 0; i < `NUM_PRI; i++) begin
                                r = rand32();
                                idx[i] = sweep ? k[5:0] : r[5:0];
                                app_raddr[i] = idx[i];
                        end
                        app_rd = mask;
                        @(negedge clk);
                end
        endtask

        // PIO read blocked by the engine for 1 to 10 cycles.
        task automatic stalled_read(input int t);
                pio_word_t r, addr;
                sch_id_t ridx;
                int len;
                r = rand32();
                len = 1 + int'(r[7:0]) % 10;
                ridx = r[21:16];
                addr = {`PRI_SCH_REGION, t[2:0], r[13:8], 2'b00};
                app_rd[t]    = 1'b1;
                app_raddr[t] = ridx;
                reg_addr     = addr;
                reg_rd       = 1'b1;
                repeat (len) begin
                        @(negedge clk);
                        reg_rd   = 1'b0;
                        reg_addr = rand32();    // Host bus moves on while the read waits.
                        reg_addr[`PIO_IDX_MSB:`PIO_IDX_LSB] = ~addr[`PIO_IDX_MSB:`PIO_IDX_LSB];
                        check_value("reg_ack", pio_word_t'(reg_ack), 0);
                        check_value("app_ack", pio_word_t'(app_ack[t]), 1);
                        check_value("app_rdata", pio_word_t'(app_rdata[t]),
                                    pio_word_t'(model[t][ridx]));
                end
                app_rd[t] = 1'b0;
                @(negedge clk);
                while (!reg_ack) @(negedge clk);
                check_value("reg_rdata", reg_rdata, expect_pio(addr));
        endtask

        // ---------------------------------------------------------------------
        // Test sequence
        // ---------------------------------------------------------------------
        initial begin
                pio_word_t q [$];
                pio_word_t r, d;
                rst_n    = 1'b0;
                reg_addr = '0;
                reg_din  = '0;
                reg_rd   = 1'b0;
                reg_wr   = 1'b0;
                app_rd   = '0;
                for (int i = 0; i < `NUM_PRI; i++) begin
                        app_raddr[i] = '0;
                end
                repeat (4) @(negedge clk);
                rst_n = 1'b1;
                repeat (3) begin
                        @(negedge clk);
                        check_value("reg_ack", pio_word_t'(reg_ack), 0);
                        check_value("app_ack", pio_word_t'(app_ack), 0);
                end
                for (int t = 0; t < `NUM_PRI; t++) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                pio_write({`PRI_SCH_REGION, t[2:0], i[5:0], 2'b00}, rand32());
                        end
                end
                for (int n = 0; n < 300; n++) begin
                        r = rand32();
                        q.push_back({`PRI_SCH_REGION, r[10:0]});        // Lane bits random.
                        pio_write(q[n], rand32());
                end
                repeat (2) @(negedge clk);
                foreach (q[k]) begin
                        pio_read(q[k], d);
                        check_value("reg_rdata", d, expect_pio(q[k]));
                end
                engine_reads(100, 1'b0);
                repeat (20) begin
                        r = rand32();
                        stalled_read(int'(r[2:0]));
                end
                repeat (16) pio_write(unmapped_addr(), rand32());
                repeat (2) @(negedge clk);
                engine_reads(DEPTH, 1'b1);
                repeat (16) begin
                        pio_read(unmapped_addr(), d);
                        check_value("reg_rdata", d, 0);
                end
                // Write one table, then compare all eight.
                repeat (8) begin
                        r = rand32();
                        pio_write({`PRI_SCH_REGION, r[10:0]}, rand32());
                        repeat (2) @(negedge clk);
                        engine_reads(DEPTH, 1'b1);
                end
                $display("Run ended with %0d checks and %0d errors.", checks, errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/tm_pkg.sv
src/pio_mem.sv
src/tm_sch_pri_mem.sv
src/pio_decode.sv
src/tm_pri_sch_ctrl_top.sv
verification/tb_tm_pri_sch_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_tm_pri_sch_ctrl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
